/* build.f */
hdl/lane_cfg_pkg.sv
hdl/lane_req_pkg.sv
hdl/req_hold_reg.sv
hdl/lane_issue.sv
hdl/operand_cmd_slots.sv
hdl/vinsn_tracker.sv
hdl/lane_sequencer.sv
test/tb_lane_sequencer.sv

/* hdl/lane_cfg_pkg.sv */
package lane_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Number of vector instructions that can be in flight
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned VInsnIdW = $clog2(NrVInsn);

  // Vector length and start index width
  localparam int unsigned VlW = 16;

  // Operand queues fed by this sequencer
  localparam int unsigned NrOperandQueues = 7;

  typedef logic [VInsnIdW-1:0] vinsn_id_t;
  typedef logic [NrVInsn-1:0]  vinsn_map_t;
  typedef logic [VlW-1:0]      vl_t;
  typedef logic [4:0]          vreg_t;

  // The mask always lives in v0
  localparam vreg_t VMaskReg = 5'd0;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} ew_e;

  typedef enum logic [1:0] {UnitAlu, UnitMFpu, UnitStore} unit_e;

  // Index of each operand queue in the command arrays
  typedef enum logic [2:0] {
    AluA, AluB, MulFpuA, MulFpuB, MulFpuC, StA, MaskM
  } opq_e;

endpackage

/* hdl/lane_issue.sv */
`timescale 1ns/1ps

module lane_issue import lane_cfg_pkg::*; import lane_req_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic     [$clog2(NrLanes)-1:0]       lane_id_i,
  input  pe_req_t                              req_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  input  logic     [NrOperandQueues-1:0]       opq_busy_i,
  input  vinsn_map_t                           running_i,
  output opq_cmd_t [NrOperandQueues-1:0]       opq_cmd_o,
  output logic     [NrOperandQueues-1:0]       opq_push_o,
  output logic                                 issue_o,
  output vinsn_id_t                            issue_id_o,
  output logic                                 zero_vl_done_o,
  output vfu_op_t                              vfu_operation_o,
  output logic                                 vfu_operation_valid_o
);

  localparam int unsigned LaneShift = $clog2(NrLanes);

  // Elements of a length that land on one lane. Lower lanes take the remainder
  function automatic vl_t lane_share(vl_t len, logic [LaneShift-1:0] lane);
    vl_t share;
    share = len >> LaneShift;
    if (lane < len[LaneShift-1:0]) share = share + vl_t'(1);
    return share;
  endfunction

  vl_t                        lane_vl;
  vl_t                        lane_vstart;
  vl_t                        store_vl;
  vl_t                        mask_vl;
  logic [NrOperandQueues-1:0] need;
  logic [NrOperandQueues-1:0] push_sel;
  logic                       fire;
  logic                       zero_vl;
  vfu_op_t                    op_d;

  ////////////////////////////////////////////////////////////
  // Length split
  ////////////////////////////////////////////////////////////

  always_comb begin
    lane_vl     = lane_share(req_i.vl, lane_id_i);
    lane_vstart = lane_share(req_i.vstart, lane_id_i);
    // The store data leaves the lane, so every lane fetches the ceiling
    store_vl    = (req_i.vl >> LaneShift) + vl_t'(|req_i.vl[LaneShift-1:0]);
    // One mask bit per element, packed into 64-bit words spread over the lanes
    mask_vl     = (req_i.vl >> (LaneShift + 3)) >> int'(req_i.vsew);
    if (((mask_vl << int'(req_i.vsew)) << (LaneShift + 3)) != req_i.vl) begin
      mask_vl = mask_vl + vl_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Readiness
  ////////////////////////////////////////////////////////////

  always_comb begin
    need = '0;
    unique case (req_i.unit)
      UnitAlu: begin
        need[AluA]  = 1'b1;
        need[AluB]  = 1'b1;
        need[MaskM] = 1'b1;
      end
      UnitMFpu: begin
        need[MulFpuA] = 1'b1;
        need[MulFpuB] = 1'b1;
        need[MulFpuC] = 1'b1;
        need[MaskM]   = 1'b1;
      end
      UnitStore: begin
        need[StA]   = 1'b1;
        need[MaskM] = 1'b1;
      end
      default: need = '0;
    endcase
  end

  // A request waits while its ID is still running in the lane
  assign req_ready_o = !running_i[req_i.id] && !(|(opq_busy_i & need));
  assign fire        = req_valid_i && req_ready_o;
  assign zero_vl     = (lane_vl == '0) && (req_i.unit inside {UnitAlu, UnitMFpu});

  assign issue_o        = fire;
  assign issue_id_o     = req_i.id;
  assign zero_vl_done_o = fire && zero_vl;

  ////////////////////////////////////////////////////////////
  // Operand commands
  ////////////////////////////////////////////////////////////

  always_comb begin
    opq_cmd_o = '0;
    push_sel  = '0;
    for (int q = 0; q < NrOperandQueues; q++) begin
      opq_cmd_o[q].id     = req_i.id;
      opq_cmd_o[q].vl     = lane_vl;
      opq_cmd_o[q].vstart = lane_vstart;
    end

    opq_cmd_o[MaskM].vs     = VMaskReg;
    opq_cmd_o[MaskM].eew    = req_i.vsew;
    opq_cmd_o[MaskM].vl     = mask_vl;
    opq_cmd_o[MaskM].hazard = req_i.hazard_vm | req_i.hazard_vd;

    unique case (req_i.unit)
      UnitAlu: begin
        opq_cmd_o[AluA].vs     = req_i.vs1;
        opq_cmd_o[AluA].eew    = req_i.eew_vs1;
        opq_cmd_o[AluA].hazard = req_i.hazard_vs1 | req_i.hazard_vd;
        opq_cmd_o[AluB].vs     = req_i.vs2;
        opq_cmd_o[AluB].eew    = req_i.eew_vs2;
        opq_cmd_o[AluB].hazard = req_i.hazard_vs2 | req_i.hazard_vd;
        push_sel[AluA]  = req_i.use_vs1;
        push_sel[AluB]  = req_i.use_vs2;
        push_sel[MaskM] = !req_i.vm;
      end
      UnitMFpu: begin
        opq_cmd_o[MulFpuA].vs     = req_i.vs1;
        opq_cmd_o[MulFpuA].eew    = req_i.eew_vs1;
        opq_cmd_o[MulFpuA].hazard = req_i.hazard_vs1 | req_i.hazard_vd;
        // For a swapped operation the B and C queues exchange vs2 and vd
        if (req_i.swap_vs2_vd_op) begin
          opq_cmd_o[MulFpuB].vs     = req_i.vd;
          opq_cmd_o[MulFpuB].eew    = req_i.eew_vd_op;
          opq_cmd_o[MulFpuB].hazard = req_i.hazard_vd;
          opq_cmd_o[MulFpuC].vs     = req_i.vs2;
          opq_cmd_o[MulFpuC].eew    = req_i.eew_vs2;
          opq_cmd_o[MulFpuC].hazard = req_i.hazard_vs2 | req_i.hazard_vd;
          push_sel[MulFpuB] = req_i.use_vd_op;
          push_sel[MulFpuC] = req_i.use_vs2;
        end else begin
          opq_cmd_o[MulFpuB].vs     = req_i.vs2;
          opq_cmd_o[MulFpuB].eew    = req_i.eew_vs2;
          opq_cmd_o[MulFpuB].hazard = req_i.hazard_vs2 | req_i.hazard_vd;
          opq_cmd_o[MulFpuC].vs     = req_i.vd;
          opq_cmd_o[MulFpuC].eew    = req_i.eew_vd_op;
          opq_cmd_o[MulFpuC].hazard = req_i.hazard_vd;
          push_sel[MulFpuB] = req_i.use_vs2;
          push_sel[MulFpuC] = req_i.use_vd_op;
        end
        push_sel[MulFpuA] = req_i.use_vs1;
        push_sel[MaskM]   = !req_i.vm;
      end
      UnitStore: begin
        opq_cmd_o[StA].vs     = req_i.vs1;
        opq_cmd_o[StA].eew    = req_i.eew_vs1;
        opq_cmd_o[StA].vl     = store_vl;
        opq_cmd_o[StA].hazard = req_i.hazard_vs1 | req_i.hazard_vd;
        push_sel[StA]   = req_i.use_vs1;
        push_sel[MaskM] = !req_i.vm;
      end
      default: push_sel = '0;
    endcase
  end

  assign opq_push_o = {NrOperandQueues{fire}} & push_sel;

  ////////////////////////////////////////////////////////////
  // Functional unit operation
  ////////////////////////////////////////////////////////////

  assign op_d = '{
    id:             req_i.id,
    op:             req_i.op,
    vm:             req_i.vm,
    unit:           req_i.unit,
    use_vs1:        req_i.use_vs1,
    use_vs2:        req_i.use_vs2,
    use_vd_op:      req_i.use_vd_op,
    swap_vs2_vd_op: req_i.swap_vs2_vd_op,
    vd:             req_i.vd,
    vsew:           req_i.vsew,
    vl:             lane_vl,
    vstart:         lane_vstart
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vfu_operation_valid_o <= 1'b0;
    end else begin
      vfu_operation_valid_o <= fire && !zero_vl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire && !zero_vl) vfu_operation_o <= op_d;
  end

endmodule

/* hdl/lane_req_pkg.sv */
package lane_req_pkg;

  import lane_cfg_pkg::*;

  // Vector instruction as handed over by the main sequencer
  typedef struct packed {
    vinsn_id_t  id;
    logic [7:0] op;
    logic       vm;
    unit_e      unit;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd_op;
    logic       swap_vs2_vd_op;
    vreg_t      vs1;
    vreg_t      vs2;
    vreg_t      vd;
    ew_e        eew_vs1;
    ew_e        eew_vs2;
    ew_e        eew_vd_op;
    ew_e        vsew;
    vl_t        vl;
    vl_t        vstart;
    // Instructions each source or destination register must wait for
    vinsn_map_t hazard_vs1;
    vinsn_map_t hazard_vs2;
    vinsn_map_t hazard_vd;
    vinsn_map_t hazard_vm;
  } pe_req_t;

  // Operation for the lane's functional unit, with lengths already split
  typedef struct packed {
    vinsn_id_t  id;
    logic [7:0] op;
    logic       vm;
    unit_e      unit;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd_op;
    logic       swap_vs2_vd_op;
    vreg_t      vd;
    ew_e        vsew;
    vl_t        vl;
    vl_t        vstart;
  } vfu_op_t;

  // Fetch command for one operand queue
  typedef struct packed {
    vinsn_id_t  id;
    vreg_t      vs;
    ew_e        eew;
    vl_t        vl;
    vl_t        vstart;
    vinsn_map_t hazard;
  } opq_cmd_t;

  // Instructions that completed in this lane
  typedef struct packed {
    vinsn_map_t vinsn_done;
  } pe_resp_t;

endpackage

/* hdl/lane_sequencer.sv */
`timescale 1ns/1ps

module lane_sequencer import lane_cfg_pkg::*; import lane_req_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic     [$clog2(NrLanes)-1:0]       lane_id_i,
  // Main sequencer
  input  pe_req_t                              pe_req_i,
  input  logic                                 pe_req_valid_i,
  output logic                                 pe_req_ready_o,
  input  vinsn_map_t                           pe_vinsn_running_i,
  output pe_resp_t                             pe_resp_o,
  // Operand requester
  output opq_cmd_t [NrOperandQueues-1:0]       operand_request_o,
  output logic     [NrOperandQueues-1:0]       operand_request_valid_o,
  input  logic     [NrOperandQueues-1:0]       operand_request_ready_i,
  // Functional units
  input  vinsn_map_t                           alu_vinsn_done_i,
  input  vinsn_map_t                           mfpu_vinsn_done_i,
  output logic                                 alu_vinsn_done_o,
  output logic                                 mfpu_vinsn_done_o,
  output vfu_op_t                              vfu_operation_o,
  output logic                                 vfu_operation_valid_o
);

  ////////////////////////////////////////////////////////////
  // Request holding register
  ////////////////////////////////////////////////////////////

  pe_req_t hold_req;
  logic    hold_valid;
  logic    issue_ready;

  req_hold_reg #(
    .T (pe_req_t)
  ) req_hold_reg_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (pe_req_i),
    .valid_i (pe_req_valid_i),
    .ready_o (pe_req_ready_o),
    .data_o  (hold_req),
    .valid_o (hold_valid),
    .ready_i (issue_ready)
  );

  ////////////////////////////////////////////////////////////
  // Issue, operand slots and tracking
  ////////////////////////////////////////////////////////////

  opq_cmd_t [NrOperandQueues-1:0] opq_cmd_d;
  logic     [NrOperandQueues-1:0] opq_push;
  logic                           issue;
  vinsn_id_t                      issue_id;
  logic                           zero_vl_done;
  vinsn_map_t                     running;

  lane_issue #(
    .NrLanes (NrLanes)
  ) lane_issue_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .lane_id_i             (lane_id_i),
    .req_i                 (hold_req),
    .req_valid_i           (hold_valid),
    .req_ready_o           (issue_ready),
    // The slot valids double as the busy flags
    .opq_busy_i            (operand_request_valid_o),
    .running_i             (running),
    .opq_cmd_o             (opq_cmd_d),
    .opq_push_o            (opq_push),
    .issue_o               (issue),
    .issue_id_o            (issue_id),
    .zero_vl_done_o        (zero_vl_done),
    .vfu_operation_o       (vfu_operation_o),
    .vfu_operation_valid_o (vfu_operation_valid_o)
  );

  operand_cmd_slots operand_cmd_slots_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (opq_cmd_d),
    .push_i  (opq_push),
    .ready_i (operand_request_ready_i),
    .cmd_o   (operand_request_o),
    .valid_o (operand_request_valid_o)
  );

  vinsn_tracker vinsn_tracker_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pe_vinsn_running_i (pe_vinsn_running_i),
    .issue_i            (issue),
    .issue_id_i         (issue_id),
    .zero_vl_done_i     (zero_vl_done),
    .alu_vinsn_done_i   (alu_vinsn_done_i),
    .mfpu_vinsn_done_i  (mfpu_vinsn_done_i),
    .running_o          (running),
    .pe_resp_o          (pe_resp_o),
    .alu_vinsn_done_o   (alu_vinsn_done_o),
    .mfpu_vinsn_done_o  (mfpu_vinsn_done_o)
  );

endmodule

/* hdl/operand_cmd_slots.sv */
`timescale 1ns/1ps

module operand_cmd_slots import lane_cfg_pkg::*; import lane_req_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  opq_cmd_t [NrOperandQueues-1:0]      cmd_i,
  input  logic     [NrOperandQueues-1:0]      push_i,
  input  logic     [NrOperandQueues-1:0]      ready_i,
  output opq_cmd_t [NrOperandQueues-1:0]      cmd_o,
  output logic     [NrOperandQueues-1:0]      valid_o
);

  logic [NrOperandQueues-1:0] valid_d;

  // The operand requester takes a command when it raises ready.
  // A new push in the same cycle refills the slot
  always_comb begin
    valid_d = valid_o;
    for (int q = 0; q < NrOperandQueues; q++) begin
      if (ready_i[q]) valid_d[q] = 1'b0;
      if (push_i[q]) valid_d[q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= '0;
    end else begin
      valid_o <= valid_d;
    end
  end

  // Command payload of each slot
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NrOperandQueues; q++) begin
      if (push_i[q]) begin
        cmd_o[q] <= cmd_i[q];
      end else if (ready_i[q]) begin
        cmd_o[q] <= '0;
      end
    end
  end

endmodule

/* hdl/req_hold_reg.sv */
`timescale 1ns/1ps

module req_hold_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  logic live_q;
  logic full_q;
  T     data_q;

  // Not ready on the first cycle out of reset, then ready whenever empty
  assign ready_o = live_q && !full_q;

  // An empty buffer lets the accepted request fall through
  assign valid_o = full_q || (valid_i && ready_o);
  assign data_o  = full_q ? data_q : data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      live_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (full_q) begin
        full_q <= !ready_i;
      end else begin
        full_q <= valid_i && ready_o && !ready_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o && !ready_i) data_q <= data_i;
  end

endmodule

/* hdl/vinsn_tracker.sv */
`timescale 1ns/1ps

module vinsn_tracker import lane_cfg_pkg::*; import lane_req_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  vinsn_map_t pe_vinsn_running_i,
  input  logic       issue_i,
  input  vinsn_id_t  issue_id_i,
  input  logic       zero_vl_done_i,
  input  vinsn_map_t alu_vinsn_done_i,
  input  vinsn_map_t mfpu_vinsn_done_i,
  output vinsn_map_t running_o,
  output pe_resp_t   pe_resp_o,
  output logic       alu_vinsn_done_o,
  output logic       mfpu_vinsn_done_o
);

  vinsn_map_t running_q;
  vinsn_map_t running_d;
  vinsn_map_t issue_map;
  vinsn_map_t done_d;

  // One-hot of the ID at the issue stage
  always_comb begin
    issue_map             = '0;
    issue_map[issue_id_i] = 1'b1;
  end

  // An ID stays running here only while the main sequencer still lists it
  assign running_o = running_q & pe_vinsn_running_i;
  assign running_d = running_o | (issue_i ? issue_map : '0);

  // A zero-length instruction never reaches a unit and completes right away
  assign done_d = alu_vinsn_done_i | mfpu_vinsn_done_i |
                  (zero_vl_done_i ? issue_map : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q         <= '0;
      pe_resp_o         <= '0;
      alu_vinsn_done_o  <= 1'b0;
      mfpu_vinsn_done_o <= 1'b0;
    end else begin
      running_q            <= running_d;
      pe_resp_o.vinsn_done <= done_d;
      alu_vinsn_done_o     <= |alu_vinsn_done_i;
      mfpu_vinsn_done_o    <= |mfpu_vinsn_done_i;
    end
  end

endmodule

/* test/tb_lane_sequencer.sv */
`timescale 1ns/1ps

module tb_lane_sequencer import lane_cfg_pkg::*; import lane_req_pkg::*; ();

  localparam int unsigned NrLanes = 4;
  // Seven short tests of at most about 60 cycles each plus reset, with a wide margin
  localparam int unsigned MaxCycles = 2000;

  logic                           clk_i;
  logic                           rst_ni;
  logic [1:0]                     lane_id_i;
  pe_req_t                        pe_req_i;
  logic                           pe_req_valid_i;
  logic                           pe_req_ready_o;
  vinsn_map_t                     pe_vinsn_running_i;
  pe_resp_t                       pe_resp_o;
  opq_cmd_t [NrOperandQueues-1:0] operand_request_o;
  logic [NrOperandQueues-1:0]     operand_request_valid_o;
  logic [NrOperandQueues-1:0]     operand_request_ready_i;
  vinsn_map_t                     alu_vinsn_done_i;
  vinsn_map_t                     mfpu_vinsn_done_i;
  logic                           alu_vinsn_done_o;
  logic                           mfpu_vinsn_done_o;
  vfu_op_t                        vfu_operation_o;
  logic                           vfu_operation_valid_o;

  int unsigned rng_state = 87;
  int unsigned cycle_count;
  int unsigned tests;
  int unsigned checks;
  int unsigned errors;
  int unsigned test_errors;
  string       cur_test;

  lane_sequencer #(
    .NrLanes (NrLanes)
  ) lane_sequencer_i (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .lane_id_i               (lane_id_i),
    .pe_req_i                (pe_req_i),
    .pe_req_valid_i          (pe_req_valid_i),
    .pe_req_ready_o          (pe_req_ready_o),
    .pe_vinsn_running_i      (pe_vinsn_running_i),
    .pe_resp_o               (pe_resp_o),
    .operand_request_o       (operand_request_o),
    .operand_request_valid_o (operand_request_valid_o),
    .operand_request_ready_i (operand_request_ready_i),
    .alu_vinsn_done_i        (alu_vinsn_done_i),
    .mfpu_vinsn_done_i       (mfpu_vinsn_done_i),
    .alu_vinsn_done_o        (alu_vinsn_done_o),
    .mfpu_vinsn_done_o       (mfpu_vinsn_done_o),
    .vfu_operation_o         (vfu_operation_o),
    .vfu_operation_valid_o   (vfu_operation_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MaxCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;
  endfunction

  // Elements of a length that fall on one lane, remainder to the low lanes
  function automatic int unsigned lane_len(input int unsigned len, input int unsigned lane);
    return len / NrLanes + ((lane < len % NrLanes) ? 1 : 0);
  endfunction

  function automatic int unsigned ceil_len(input int unsigned len);
    return (len + NrLanes - 1) / NrLanes;
  endfunction

  function automatic int unsigned mask_len(input int unsigned len, input int unsigned sew);
    int unsigned words;
    words = (len / (NrLanes * 8)) >> sew;
    if (((words << sew) * NrLanes * 8) != len) words = words + 1;
    return words;
  endfunction

  function automatic pe_req_t make_req(input vinsn_id_t id, input unit_e unit,
                                       input vl_t vl, input vl_t vstart);
    pe_req_t r;
    r            = '0;
    r.id         = id;
    r.op         = 8'h40 | 8'(id);
    r.vm         = 1'b1;
    r.unit       = unit;
    r.vs1        = 5'd4;
    r.vs2        = 5'd8;
    r.vd         = 5'd12;
    r.eew_vs1    = EW32;
    r.eew_vs2    = EW16;
    r.eew_vd_op  = EW64;
    r.vsew       = EW32;
    r.vl         = vl;
    r.vstart     = vstart;
    r.hazard_vs1 = 8'h01;
    r.hazard_vs2 = 8'h02;
    r.hazard_vd  = 8'h10;
    r.hazard_vm  = 8'h80;
    return r;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      $display("Error in %s: %s", cur_test, msg);
      errors++;
    end
  endtask

  task automatic check_cmd(input string name, input opq_e q, input vreg_t vs, input ew_e eew,
                           input int unsigned vl, input vinsn_map_t hazard);
    check_val({name, " vs"}, vs, operand_request_o[q].vs);
    check_val({name, " eew"}, eew, operand_request_o[q].eew);
    check_val({name, " vl"}, vl, operand_request_o[q].vl);
    check_val({name, " hazard"}, hazard, operand_request_o[q].hazard);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%s finished with %0d errors", cur_test, errors - test_errors);
  endtask

  // Holds the request on the bus until the holding register takes it
  task automatic send_req(input pe_req_t req);
    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
  endtask

  task automatic wait_op(output bit seen);
    seen = 1'b0;
    for (int i = 0; i < 16 && !seen; i++) begin
      @(negedge clk_i);
      seen = vfu_operation_valid_o;
    end
  endtask

  task automatic drain_slots();
    @(posedge clk_i);
    operand_request_ready_i <= '1;
    @(posedge clk_i);
    operand_request_ready_i <= '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_values();
    start_test("reset_values");
    check_val("pe_req_ready", 1'b0, pe_req_ready_o);
    check_val("slot valids", 7'b0000000, operand_request_valid_o);
    check_val("vfu valid", 1'b0, vfu_operation_valid_o);
    check_val("pe_resp", 8'h00, pe_resp_o.vinsn_done);
    check_val("done flags", 2'b00, {alu_vinsn_done_o, mfpu_vinsn_done_o});
    end_test();
  endtask

  task automatic alu_issue();
    pe_req_t     req;
    int unsigned vl;
    int unsigned vstart;
    int unsigned lane;
    bit          seen;
    start_test("alu_issue");
    for (int i = 0; i < 4; i++) begin
      vl          = NrLanes + next_rand() % 400;
      vstart      = next_rand() % 64;
      lane        = next_rand() % NrLanes;
      req         = make_req(vinsn_id_t'(i), UnitAlu, vl_t'(vl), vl_t'(vstart));
      req.use_vs1 = i[0];
      req.use_vs2 = i[1];
      req.vm      = i[0];
      req.vsew    = ew_e'(next_rand() % 4);
      @(posedge clk_i);
      lane_id_i <= lane[1:0];
      send_req(req);
      wait_op(seen);
      check_true(seen, "no operation reached the ALU");
      check_val("op vl", lane_len(vl, lane), vfu_operation_o.vl);
      check_val("op vstart", lane_len(vstart, lane), vfu_operation_o.vstart);
      check_val("op id", req.id, vfu_operation_o.id);
      check_val("op code", req.op, vfu_operation_o.op);
      check_val("op vm", req.vm, vfu_operation_o.vm);
      check_val("op vd", req.vd, vfu_operation_o.vd);
      check_val("op vsew", req.vsew, vfu_operation_o.vsew);
      check_val("op operands", {req.use_vs1, req.use_vs2},
                {vfu_operation_o.use_vs1, vfu_operation_o.use_vs2});
      check_val("AluA valid", req.use_vs1, operand_request_valid_o[AluA]);
      check_val("AluB valid", req.use_vs2, operand_request_valid_o[AluB]);
      check_val("MaskM valid", !req.vm, operand_request_valid_o[MaskM]);
      check_val("other valids", 4'b0000, operand_request_valid_o[5:2]);
      if (req.use_vs1) check_cmd("AluA", AluA, 5'd4, EW32, lane_len(vl, lane), 8'h11);
      if (req.use_vs2) check_cmd("AluB", AluB, 5'd8, EW16, lane_len(vl, lane), 8'h12);
      if (!req.vm) begin
        check_cmd("MaskM", MaskM, VMaskReg, req.vsew, mask_len(vl, req.vsew), 8'h90);
      end
      drain_slots();
    end
    end_test();
  endtask

  task automatic mfpu_swap();
    pe_req_t     req;
    int unsigned vl;
    bit          seen;
    start_test("mfpu_swap");
    // Case bit 1 selects the swap, bit 0 the use of vd as an operand
    for (int c = 0; c < 4; c++) begin
      vl                 = NrLanes + next_rand() % 200;
      req                = make_req(vinsn_id_t'(c + 4), UnitMFpu, vl_t'(vl), '0);
      req.use_vs1        = 1'b1;
      req.use_vs2        = 1'b1;
      req.use_vd_op      = c[0];
      req.swap_vs2_vd_op = c[1];
      @(posedge clk_i);
      lane_id_i <= 2'd0;
      send_req(req);
      wait_op(seen);
      check_true(seen, "no operation reached the multiplier");
      check_val("op unit", UnitMFpu, vfu_operation_o.unit);
      check_val("op swap", c[1], vfu_operation_o.swap_vs2_vd_op);
      check_val("op use_vd_op", c[0], vfu_operation_o.use_vd_op);
      check_val("MulFpuA valid", 1'b1, operand_request_valid_o[MulFpuA]);
      check_cmd("MulFpuA", MulFpuA, 5'd4, EW32, lane_len(vl, 0), 8'h11);
      check_val("ALU valids", 2'b00, operand_request_valid_o[1:0]);
      if (c[1]) begin
        check_val("MulFpuB valid", c[0], operand_request_valid_o[MulFpuB]);
        check_val("MulFpuC valid", 1'b1, operand_request_valid_o[MulFpuC]);
        if (c[0]) check_cmd("MulFpuB", MulFpuB, 5'd12, EW64, lane_len(vl, 0), 8'h10);
        check_cmd("MulFpuC", MulFpuC, 5'd8, EW16, lane_len(vl, 0), 8'h12);
      end else begin
        check_val("MulFpuB valid", 1'b1, operand_request_valid_o[MulFpuB]);
        check_val("MulFpuC valid", c[0], operand_request_valid_o[MulFpuC]);
        check_cmd("MulFpuB", MulFpuB, 5'd8, EW16, lane_len(vl, 0), 8'h12);
        if (c[0]) check_cmd("MulFpuC", MulFpuC, 5'd12, EW64, lane_len(vl, 0), 8'h10);
      end
      drain_slots();
    end
    end_test();
  endtask

  task automatic store_data();
    pe_req_t     req;
    int unsigned vl;
    bit          seen;
    start_test("store_data");
    for (int i = 0; i < 2; i++) begin
      vl          = NrLanes + next_rand() % 300;
      req         = make_req(vinsn_id_t'(i + 1), UnitStore, vl_t'(vl), '0);
      req.use_vs1 = 1'b1;
      req.vm      = 1'b0;
      @(posedge clk_i);
      lane_id_i <= 2'(next_rand() % NrLanes);
      send_req(req);
      wait_op(seen);
      check_true(seen, "no operation was issued for the store");
      check_val("op unit", UnitStore, vfu_operation_o.unit);
      check_val("StA valid", 1'b1, operand_request_valid_o[StA]);
      check_cmd("StA", StA, 5'd4, EW32, ceil_len(vl), 8'h11);
      check_val("ALU and MFpu valids", 5'b00000, operand_request_valid_o[4:0]);
      check_val("MaskM valid", 1'b1, operand_request_valid_o[MaskM]);
      drain_slots();
    end
    end_test();
  endtask

  task automatic zero_length();
    pe_req_t req;
    start_test("zero_length");
    req         = make_req(vinsn_id_t'(5), UnitAlu, vl_t'(2), '0);
    req.use_vs1 = 1'b1;
    @(posedge clk_i);
    lane_id_i <= 2'd3;
    send_req(req);
    @(negedge clk_i);
    check_val("pe_resp", 8'h20, pe_resp_o.vinsn_done);
    check_true(!vfu_operation_valid_o, "an operation was issued with a zero lane length");
    repeat (3) begin
      @(negedge clk_i);
      check_true(!vfu_operation_valid_o, "an operation was issued with a zero lane length");
    end
    drain_slots();
    end_test();
  endtask

  task automatic back_pressure();
    pe_req_t  req_a;
    pe_req_t  req_b;
    opq_cmd_t snap_a;
    opq_cmd_t snap_b;
    bit       seen;
    start_test("back_pressure");
    req_a         = make_req(vinsn_id_t'(1), UnitAlu, vl_t'(37), vl_t'(6));
    req_a.use_vs1 = 1'b1;
    req_a.use_vs2 = 1'b1;
    req_b         = make_req(vinsn_id_t'(2), UnitAlu, vl_t'(90), vl_t'(9));
    req_b.use_vs1 = 1'b1;
    req_b.use_vs2 = 1'b1;
    @(posedge clk_i);
    lane_id_i <= 2'd1;
    send_req(req_a);
    wait_op(seen);
    check_true(seen, "the first request was not issued");
    snap_a = operand_request_o[AluA];
    snap_b = operand_request_o[AluB];
    // The slots stay full, so the second request parks in the holding register
    send_req(req_b);
    repeat (5) begin
      @(negedge clk_i);
      check_val("pe_req_ready", 1'b0, pe_req_ready_o);
      check_true(!vfu_operation_valid_o, "the second request issued into busy slots");
      check_val("AluA held", snap_a, operand_request_o[AluA]);
      check_val("AluB held", snap_b, operand_request_o[AluB]);
    end
    drain_slots();
    wait_op(seen);
    check_true(seen, "the second request did not issue after the slots drained");
    check_val("second op id", 2, vfu_operation_o.id);
    check_val("second op vl", lane_len(90, 1), vfu_operation_o.vl);
    check_cmd("second AluA", AluA, 5'd4, EW32, lane_len(90, 1), 8'h11);
    check_val("second AluA id", 2, operand_request_o[AluA].id);
    drain_slots();

    // An ID still listed as running by the main sequencer must wait
    @(posedge clk_i);
    pe_vinsn_running_i <= 8'h08;
    req_a.id = vinsn_id_t'(3);
    send_req(req_a);
    wait_op(seen);
    check_true(seen, "the first request with ID 3 was not issued");
    drain_slots();
    req_b.id = vinsn_id_t'(3);
    send_req(req_b);
    repeat (4) begin
      @(negedge clk_i);
      check_true(!vfu_operation_valid_o, "a request issued while its ID was running");
      check_val("pe_req_ready while running", 1'b0, pe_req_ready_o);
    end
    @(posedge clk_i);
    pe_vinsn_running_i <= '0;
    wait_op(seen);
    check_true(seen, "the waiting request did not issue after its ID finished");
    check_val("released op vl", lane_len(90, 1), vfu_operation_o.vl);
    drain_slots();
    end_test();
  endtask

  task automatic done_reporting();
    start_test("done_reporting");
    @(posedge clk_i);
    alu_vinsn_done_i <= 8'h05;
    @(posedge clk_i);
    alu_vinsn_done_i  <= '0;
    mfpu_vinsn_done_i <= 8'h40;
    @(negedge clk_i);
    check_val("pe_resp after ALU done", 8'h05, pe_resp_o.vinsn_done);
    check_val("alu done", 1'b1, alu_vinsn_done_o);
    check_val("mfpu done", 1'b0, mfpu_vinsn_done_o);
    @(posedge clk_i);
    mfpu_vinsn_done_i <= '0;
    @(negedge clk_i);
    check_val("pe_resp after MFpu done", 8'h40, pe_resp_o.vinsn_done);
    check_val("alu done", 1'b0, alu_vinsn_done_o);
    check_val("mfpu done", 1'b1, mfpu_vinsn_done_o);
    @(negedge clk_i);
    check_val("pe_resp idle", 8'h00, pe_resp_o.vinsn_done);
    check_val("done flags idle", 2'b00, {alu_vinsn_done_o, mfpu_vinsn_done_o});
    end_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    tests                   = 0;
    checks                  = 0;
    errors                  = 0;
    rst_ni                  = 1'b0;
    lane_id_i               = '0;
    pe_req_i                = '0;
    pe_req_valid_i          = 1'b0;
    pe_vinsn_running_i      = '0;
    operand_request_ready_i = '0;
    alu_vinsn_done_i        = '0;
    mfpu_vinsn_done_i       = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    reset_values();
    repeat (2) @(posedge clk_i);
    alu_issue();
    mfpu_swap();
    store_data();
    zero_length();
    back_pressure();
    done_reporting();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
